/* serial_frame_pkg.sv */
package serial_frame_pkg;

  // ----------------------------------------------------------
  // Character framing
  // ----------------------------------------------------------

  // Data bits carried in one frame
  localparam int unsigned data_bits = 8;

  // Every frame opens with exactly one low start bit
  localparam int unsigned start_bits = 1;

  // One character, the LSB goes out on the line first
  typedef logic [data_bits-1:0] data_t;

  // Number of bit times in a whole frame for a given stop bit count
  function automatic int unsigned frame_bits(int unsigned stop_bits);
    return start_bits + data_bits + stop_bits;
  endfunction

  // ----------------------------------------------------------
  // Receive line faults
  // ----------------------------------------------------------

  // Each flag is sticky in the receiver and is left only by reset
  typedef struct packed {
    // The stop bit was sampled low
    logic over_run;
    // The start bit had already ended at mid-bit
    logic under_run;
    // The whole frame, stop bit included, was low
    logic all_low;
  } rx_error_t;

endpackage

/* baud_pkg.sv */
package baud_pkg;

  // ----------------------------------------------------------
  // Tick generator sizing
  // ----------------------------------------------------------

  // Width of the DDS phase accumulator
  localparam int unsigned dds_bits = 6;

  // Width of the prescaler counter in front of the DDS
  localparam int unsigned prescale_bits = 3;

  // Rate index; the three top codes all fall back to the fastest rate
  typedef enum logic [2:0] {
    rate_9600       = 3'b000,
    rate_19200      = 3'b001,
    rate_38400      = 3'b010,
    rate_57600      = 3'b011,
    rate_115200     = 3'b100,
    rate_115200_b5  = 3'b101,
    rate_115200_b6  = 3'b110,
    rate_115200_b7  = 3'b111
  } rate_sel_t;

  // One entry of the rate table
  typedef struct packed {
    // Added to the phase once per prescale period
    logic [dds_bits-2:0]      increment;
    // Prescale divide, the DDS steps once every divide clocks
    logic [prescale_bits-1:0] divide;
  } dds_setting_t;

  // Table built for a 49.152 MHz clock with 16 ticks per bit
  // The ratio 320 = 5 * 64 sets the divide to 5 and the DDS to 6 bits
  function automatic dds_setting_t rate_setting(rate_sel_t sel);
    dds_setting_t setting;
    setting.divide = prescale_bits'(5);
    case (sel)
      rate_9600:   setting.increment = (dds_bits-1)'(1);
      rate_19200:  setting.increment = (dds_bits-1)'(2);
      rate_38400:  setting.increment = (dds_bits-1)'(4);
      // The two fast rates are not exact and show some jitter
      rate_57600:  setting.increment = (dds_bits-1)'(6);
      default:     setting.increment = (dds_bits-1)'(12);
    endcase
    return setting;
  endfunction

endpackage

/* baud_tick_gen.sv */
module baud_tick_gen (
  input  logic               clk,
  input  logic               reset,
  input  baud_pkg::rate_sel_t rate_select,
  output logic               tick
);

  // Current entry of the rate table
  baud_pkg::dds_setting_t setting;

  logic [baud_pkg::prescale_bits-1:0] prescale_count;
  logic                               prescale_wrap;
  logic [baud_pkg::dds_bits-1:0]      phase;
  logic                               phase_msb_q;

  assign setting = baud_pkg::rate_setting(rate_select);

  // ----------------------------------------------------------
  // Prescaler
  // ----------------------------------------------------------

  // Wraps once every divide clocks
  // The compare is >= so a rate change can never strand the count above the limit
  assign prescale_wrap = (prescale_count >= setting.divide - 1'b1);

  always_ff @(posedge clk)
  begin
    if (reset || prescale_wrap)
      prescale_count <= '0;
    else
      prescale_count <= prescale_count + 1'b1;
  end

  // ----------------------------------------------------------
  // DDS phase accumulator and edge detector
  // ----------------------------------------------------------

  // The phase steps by the increment on every prescale wrap
  // Overflow is the intended modulo behavior of the DDS
  always_ff @(posedge clk)
  begin
    if (reset)
      phase <= '0;
    else if (prescale_wrap)
      phase <= phase + {1'b0, setting.increment};
  end

  // The MSB is a square wave at the tick rate, delayed one clock here
  always_ff @(posedge clk)
  begin
    if (reset)
      phase_msb_q <= 1'b0;
    else
      phase_msb_q <= phase[baud_pkg::dds_bits-1];
  end

  // One clock pulse on each rising edge of the MSB
  assign tick = phase[baud_pkg::dds_bits-1] & ~phase_msb_q;

  // The receiver and transmitter count ticks, so a double pulse would skew bits
  // A tick can only come right after the phase stepped on a prescale wrap
  tick_single_cycle: assert property (@(posedge clk) disable iff (reset)
    tick |-> $past(prescale_wrap) && !$past(tick));

endmodule

/* uart_tx.sv */
module uart_tx #(
  parameter int unsigned clock_factor = 16,
  parameter int unsigned stop_bits    = 1
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    tick,
  input  serial_frame_pkg::data_t tx_data,
  input  logic                    tx_valid,
  output logic                    tx_ready,
  output logic                    txd
);

  localparam int unsigned total_bits = serial_frame_pkg::frame_bits(stop_bits);
  localparam int unsigned count_bits = $clog2(clock_factor);
  localparam int unsigned bit_bits   = $clog2(total_bits);
  localparam logic [count_bits-1:0] tick_last = count_bits'(clock_factor - 1);
  localparam logic [bit_bits-1:0]   bit_last  = bit_bits'(total_bits - 2);

  typedef enum logic [1:0] {
    tx_idle,
    tx_sending,
    tx_last_bit
  } tx_state_t;

  tx_state_t                 state;
  tx_state_t                 next_state;
  logic [count_bits-1:0]     tick_count;
  logic [bit_bits-1:0]       bit_count;
  logic [total_bits-1:0]     shifter;
  logic                      bit_strobe;
  logic                      begin_last_bit;
  logic                      start_sending;

  // ----------------------------------------------------------
  // Bit timing
  // ----------------------------------------------------------

  // Divides the oversampling tick down to one strobe per bit
  always_ff @(posedge clk)
  begin
    if (reset)
      tick_count <= '0;
    else if (tick)
      tick_count <= (tick_count == tick_last) ? '0 : tick_count + 1'b1;
  end

  assign bit_strobe = tick && (tick_count == tick_last);

  // Counts strobes since the frame was loaded, to find the last stop bit
  always_ff @(posedge clk)
  begin
    if (reset || start_sending)
      bit_count <= '0;
    else if (bit_strobe)
      bit_count <= (bit_count == bit_last) ? '0 : bit_count + 1'b1;
  end

  assign begin_last_bit = bit_strobe && (bit_count == bit_last);

  // ----------------------------------------------------------
  // Framing FSM
  // ----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= tx_idle;
    else
      state <= next_state;
  end

  // A new frame may start on a strobe while idle or while the last stop bit is out
  // Taking a byte in the last bit state gives frames with no gap between them
  assign tx_ready      = bit_strobe && (state == tx_idle || state == tx_last_bit);
  assign start_sending = tx_ready && tx_valid;

  always_comb
  begin
    next_state = state;
    case (state)
      tx_idle:     if (start_sending) next_state = tx_sending;
      tx_sending:  if (begin_last_bit) next_state = tx_last_bit;
      tx_last_bit:
        if (start_sending)
          next_state = tx_sending;
        else if (bit_strobe)
          next_state = tx_idle;
      default:     next_state = tx_idle;
    endcase
  end

  // Shifter holds start bit, data and stop bits; ones fill from the top
  always_ff @(posedge clk)
  begin
    if (reset)
      shifter <= '1;
    else if (start_sending)
      shifter <= {{stop_bits{1'b1}}, tx_data, {serial_frame_pkg::start_bits{1'b0}}};
    else if (bit_strobe)
      shifter <= {1'b1, shifter[total_bits-1:1]};
  end

  assign txd = shifter[0];

  // The handshake only opens on a tick and while the line is back at its high level
  ready_on_tick: assert property (@(posedge clk) disable iff (reset)
    tx_ready |-> tick && txd);

endmodule

/* uart_rx.sv */
module uart_rx #(
  parameter int unsigned clock_factor = 16,
  parameter int unsigned stop_bits    = 1
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        tick,
  input  logic                        rxd,
  output serial_frame_pkg::data_t     rx_data,
  output logic                        rx_valid,
  input  logic                        rx_ready,
  output serial_frame_pkg::rx_error_t rx_error
);

  localparam int unsigned total_bits = serial_frame_pkg::frame_bits(stop_bits);
  localparam int unsigned count_bits = $clog2(clock_factor);
  localparam logic [count_bits-1:0] tick_last = count_bits'(clock_factor - 1);
  localparam logic [count_bits-1:0] tick_mid  = count_bits'(clock_factor / 2);

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_shift,
    rx_over_run,
    rx_under_run,
    rx_all_low
  } rx_state_t;

  typedef enum logic {
    buf_empty,
    buf_full
  } buf_state_t;

  rx_state_t             state;
  rx_state_t             next_state;
  buf_state_t            buf_state;
  buf_state_t            buf_next;
  logic [count_bits-1:0] intrabit_count;
  logic [total_bits-1:0] shifter;
  logic                  shifter_preset;
  logic                  mid_bit;
  logic                  start_bit;
  logic                  stop_bit;
  logic                  all_low;
  logic                  word_xfer;

  // ----------------------------------------------------------
  // Mid-bit timer and shifter
  // ----------------------------------------------------------

  // Idle and fault states hold the timer and the shifter in preset
  assign shifter_preset = (state == rx_idle) || (state == rx_over_run) ||
                          (state == rx_under_run) || (state == rx_all_low);

  always_ff @(posedge clk)
  begin
    if (reset || shifter_preset)
      intrabit_count <= '0;
    else if (tick)
      intrabit_count <= (intrabit_count == tick_last) ? '0 : intrabit_count + 1'b1;
  end

  // One tick per bit, halfway through it
  assign mid_bit = tick && (intrabit_count == tick_mid);

  // Samples enter at the top; the low start bit acts as the end marker
  always_ff @(posedge clk)
  begin
    if (shifter_preset)
      shifter <= '1;
    else if (mid_bit)
      shifter <= {rxd, shifter[total_bits-1:1]};
  end

  // The frame is complete once the start bit has reached the bottom
  assign start_bit = shifter[0];
  assign stop_bit  = shifter[total_bits-1];
  assign all_low   = ~|shifter;

  // ----------------------------------------------------------
  // Line FSM
  // ----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= rx_idle;
    else
      state <= next_state;
  end

  // Fault states have no way out, only reset leaves them
  always_comb
  begin
    next_state = state;
    case (state)
      rx_idle:  if (!rxd) next_state = rx_start;
      rx_start:
        if (mid_bit)
          next_state = rxd ? rx_under_run : rx_shift;
      rx_shift:
        if (all_low)
          next_state = rx_all_low;
        else if (!start_bit)
          next_state = stop_bit ? rx_idle : rx_over_run;
      rx_over_run, rx_under_run, rx_all_low: next_state = state;
      default:  next_state = rx_idle;
    endcase
  end

  assign word_xfer = (state == rx_shift) && !start_bit && stop_bit;

  assign rx_error.over_run  = (state == rx_over_run);
  assign rx_error.under_run = (state == rx_under_run);
  assign rx_error.all_low   = (state == rx_all_low);

  // ----------------------------------------------------------
  // Held output buffer
  // ----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      buf_state <= buf_empty;
    else
      buf_state <= buf_next;
  end

  // A new frame wins over a read in the same cycle, so no byte is dropped unseen
  always_comb
  begin
    buf_next = buf_state;
    if (word_xfer)
      buf_next = buf_full;
    else if (buf_state == buf_full && rx_ready)
      buf_next = buf_empty;
  end

  assign rx_valid = (buf_state == buf_full);

  // A later frame overwrites an unread byte
  always_ff @(posedge clk)
  begin
    if (reset)
      rx_data <= '0;
    else if (word_xfer)
      rx_data <= shifter[serial_frame_pkg::start_bits +: serial_frame_pkg::data_bits];
  end

  // Back-pressure holds the byte until the reader takes it
  rx_hold: assert property (@(posedge clk) disable iff (reset)
    rx_valid && !rx_ready && !word_xfer |=> rx_valid && $stable(rx_data));

endmodule

/* uart_core.sv */
module uart_core #(
  parameter int unsigned clock_factor = 16,
  parameter int unsigned stop_bits    = 1
) (
  input  logic                        clk,
  input  logic                        reset,
  input  baud_pkg::rate_sel_t         rate_select,
  input  serial_frame_pkg::data_t     tx_data,
  input  logic                        tx_valid,
  output logic                        tx_ready,
  output logic                        txd,
  output serial_frame_pkg::data_t     rx_data,
  output logic                        rx_valid,
  input  logic                        rx_ready,
  input  logic                        rxd,
  output serial_frame_pkg::rx_error_t rx_error
);

  // Oversampling enable shared by both directions
  logic tick;

  baud_tick_gen u_baud_tick_gen (
    .clk         (clk),
    .reset       (reset),
    .rate_select (rate_select),
    .tick        (tick)
  );

  // Transmit and receive run from the same tick, so both use one bit time
  uart_tx #(
    .clock_factor (clock_factor),
    .stop_bits    (stop_bits)
  ) u_uart_tx (
    .clk      (clk),
    .reset    (reset),
    .tick     (tick),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .txd      (txd)
  );

  uart_rx #(
    .clock_factor (clock_factor),
    .stop_bits    (stop_bits)
  ) u_uart_rx (
    .clk      (clk),
    .reset    (reset),
    .tick     (tick),
    .rxd      (rxd),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready),
    .rx_error (rx_error)
  );

endmodule

/* tb_uart_core.sv */
module tb_uart_core;

  timeunit 1ns;
  timeprecision 1ps;

  // Matches the core defaults, since the instance keeps them
  localparam int clock_factor = 16;
  localparam int stop_bits    = 1;
  localparam int frame_bits   = 1 + serial_frame_pkg::data_bits + stop_bits;
  // Longest wait for any handshake in clocks
  localparam int wait_limit   = 150000;

  logic                        clk;
  logic                        reset;
  baud_pkg::rate_sel_t         rate_select;
  serial_frame_pkg::data_t     tx_data;
  logic                        tx_valid;
  logic                        tx_ready;
  logic                        txd;
  serial_frame_pkg::data_t     rx_data;
  logic                        rx_valid;
  logic                        rx_ready;
  logic                        rxd;
  serial_frame_pkg::rx_error_t rx_error;

  // High loops txd back to rxd, low hands the line to the serial model
  logic                        loopback;
  logic                        model_rxd;
  integer                      seed;
  longint                      cycle_count;
  int                          tick_clocks;
  serial_frame_pkg::data_t     expected[$];

  uart_core u_uart_core (
    .clk         (clk),
    .reset       (reset),
    .rate_select (rate_select),
    .tx_data     (tx_data),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready),
    .txd         (txd),
    .rx_data     (rx_data),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .rxd         (rxd),
    .rx_error    (rx_error)
  );

  assign rxd = loopback ? txd : model_rxd;

  always #10 clk = ~clk;

  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic timed_out(string what);
    $display("Timeout at %0t ns: %s", $time, what);
    stop_run();
  endtask

  task automatic check_data(string name, serial_frame_pkg::data_t exp,
                            serial_frame_pkg::data_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_error(string name, serial_frame_pkg::rx_error_t exp,
                             serial_frame_pkg::rx_error_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  // ----------------------------------------------------------
  // Reset and loopback traffic
  // ----------------------------------------------------------

  // Leaves the caller on the falling edge where reset drops
  task automatic reset_dut(baud_pkg::rate_sel_t rate);
    @(negedge clk);
    rate_select = rate;
    reset = 1'b1;
    tx_valid = 1'b0;
    rx_ready = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    check_bit("txd", 1'b1, txd);
    check_bit("tx_ready", 1'b0, tx_ready);
    check_bit("rx_valid", 1'b0, rx_valid);
    check_error("rx_error", '0, rx_error);
  endtask

  // Holds tx_valid high so each byte is taken at the end of the previous stop bit
  task automatic send_burst(int count);
    serial_frame_pkg::data_t value;
    longint                  last_accept;
    int                      waited;
    int                      i;
    last_accept = 0;
    for (i = 0; i < count; i++)
    begin
      value = serial_frame_pkg::data_t'($random(seed));
      tx_data = value;
      tx_valid = 1'b1;
      waited = 0;
      while (!tx_ready)
      begin
        @(negedge clk);
        waited++;
        if (waited > wait_limit)
          timed_out("tx_ready never rose to take the next byte");
      end
      // The byte is taken on the coming rising edge, so a longer spacing means
      // txd stayed high past the stop bits
      if (i > 0 && cycle_count - last_accept >
          frame_bits * clock_factor * tick_clocks + tick_clocks)
      begin
        $display("Frames were not sent back to back, %0d clocks apart at %0t ns",
                 cycle_count - last_accept, $time);
        stop_run();
      end
      last_accept = cycle_count;
      expected.push_back(value);
      @(negedge clk);
    end
    tx_valid = 1'b0;
  endtask

  // Each byte is held off for a random time to test back-pressure
  task automatic collect_bytes(int count);
    serial_frame_pkg::data_t held;
    int                      waited;
    int                      hold_cycles;
    int                      i;
    for (i = 0; i < count; i++)
    begin
      waited = 0;
      while (!rx_valid)
      begin
        @(negedge clk);
        waited++;
        if (waited > wait_limit)
          timed_out("rx_valid never rose for a looped back byte");
      end
      if (expected.size() == 0)
      begin
        $display("A byte arrived at %0t ns with none outstanding", $time);
        stop_run();
      end
      held = expected.pop_front();
      check_data("rx_data", held, rx_data);
      check_error("rx_error", '0, rx_error);
      hold_cycles = {$random(seed)} % 200;
      repeat (hold_cycles)
      begin
        @(negedge clk);
        check_bit("rx_valid", 1'b1, rx_valid);
        check_data("rx_data", held, rx_data);
      end
      rx_ready = 1'b1;
      @(negedge clk);
      rx_ready = 1'b0;
      check_bit("rx_valid", 1'b0, rx_valid);
    end
  endtask

  task automatic loopback_run(baud_pkg::rate_sel_t rate, int tick_period, int count);
    tick_clocks = tick_period;
    loopback = 1'b1;
    reset_dut(rate);
    fork
      send_burst(count);
      collect_bytes(count);
    join
    // Transmitter is back in its stop bit or idle with nothing offered
    check_bit("txd", 1'b1, txd);
  endtask

  // ----------------------------------------------------------
  // Serial line model
  // ----------------------------------------------------------

  task automatic hold_line(logic level, int cycles);
    model_rxd = level;
    repeat (cycles) @(negedge clk);
  endtask

  // Start bit, data LSB first, then the stop bits at the chosen level
  task automatic drive_frame(serial_frame_pkg::data_t value, logic stop_level);
    int i;
    hold_line(1'b0, clock_factor * tick_clocks);
    for (i = 0; i < serial_frame_pkg::data_bits; i++)
      hold_line(value[i], clock_factor * tick_clocks);
    hold_line(stop_level, stop_bits * clock_factor * tick_clocks);
    model_rxd = 1'b1;
  endtask

  // Waits for the fault, then watches that it sticks and nothing is delivered
  task automatic expect_fault(serial_frame_pkg::rx_error_t exp);
    int waited;
    waited = 0;
    while (rx_error === '0)
    begin
      @(negedge clk);
      waited++;
      if (waited > 4 * clock_factor * tick_clocks)
        timed_out("rx_error never flagged the line fault");
    end
    check_error("rx_error", exp, rx_error);
    repeat (3 * clock_factor * tick_clocks)
    begin
      @(negedge clk);
      check_error("rx_error", exp, rx_error);
      check_bit("rx_valid", 1'b0, rx_valid);
    end
  endtask

  initial
  begin
    serial_frame_pkg::data_t value;
    seed = 32'ha6;
    clk = 1'b0;
    reset = 1'b1;
    rate_select = baud_pkg::rate_38400;
    tx_data = '0;
    tx_valid = 1'b0;
    rx_ready = 1'b0;
    loopback = 1'b1;
    model_rxd = 1'b1;
    cycle_count = 0;
    tick_clocks = 80;

    // Tick periods are 320, 160 and 80 clocks at these three settings
    loopback_run(baud_pkg::rate_9600, 320, 3);
    loopback_run(baud_pkg::rate_19200, 160, 4);
    loopback_run(baud_pkg::rate_38400, 80, 8);

    // Line faults come from the model at the 80 clock tick
    tick_clocks = 80;
    loopback = 1'b0;
    model_rxd = 1'b1;
    reset_dut(baud_pkg::rate_38400);
    hold_line(1'b1, 2 * clock_factor * tick_clocks);
    // A set bit keeps the bad frame from reading as all low
    value = serial_frame_pkg::data_t'($random(seed));
    value = value | 8'h01;
    drive_frame(value, 1'b0);
    expect_fault('{over_run: 1'b1, default: 1'b0});
    // A good frame after the fault must not wake the receiver
    drive_frame(value, 1'b1);
    expect_fault('{over_run: 1'b1, default: 1'b0});

    reset_dut(baud_pkg::rate_38400);
    hold_line(1'b1, clock_factor * tick_clocks);
    hold_line(1'b0, clock_factor * tick_clocks / 4 - 40);
    hold_line(1'b1, clock_factor * tick_clocks);
    expect_fault('{under_run: 1'b1, default: 1'b0});

    reset_dut(baud_pkg::rate_38400);
    hold_line(1'b0, 12 * clock_factor * tick_clocks);
    hold_line(1'b1, clock_factor * tick_clocks);
    expect_fault('{all_low: 1'b1, default: 1'b0});

    $display("Verification passed");
    $finish;
  end

endmodule

/* uart_core.f */
serial_frame_pkg.sv
baud_pkg.sv
baud_tick_gen.sv
uart_tx.sv
uart_rx.sv
uart_core.sv
tb_uart_core.sv

/* Bender.yml */
package:
  name: uart_core

sources:
  - serial_frame_pkg.sv
  - baud_pkg.sv
  - baud_tick_gen.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_core.sv
  - target: simulation
    files:
      - tb_uart_core.sv
